// ==== source/nn_cfg.svh ====
`ifndef NN_CFG_SVH
`define NN_CFG_SVH

////////////////////////////////////////
// layer geometry
////////////////////////////////////////

// upper bound on active inputs per neuron
`define NN_INPUTS 8

// neurons working in parallel
`define NN_NEURONS 4

////////////////////////////////////////
// number formats
////////////////////////////////////////

// activation width, also the width of each neuron output
`define NN_DATA_W 10

// signed weight width
`define NN_WEIGHT_W 16

// fraction bits removed when the accumulator is scaled to an output
`define NN_FRAC 4

`endif

// ==== source/nn_data_pkg.sv ====
`include "nn_cfg.svh"

package nn_data_pkg;

    ////////////////////////////////////////
    // scalar formats
    ////////////////////////////////////////

    typedef logic signed [`NN_DATA_W-1:0]          act_t;        // one activation
    typedef logic signed [`NN_WEIGHT_W-1:0]        weight_t;     // one weight
    typedef logic signed [`NN_DATA_W+`NN_FRAC-1:0] acc_t;        // running sum, wraps
    typedef logic [$clog2(`NN_INPUTS+1)-1:0]       count_t;      // 0 up to NN_INPUTS
    typedef logic [$clog2(`NN_NEURONS)-1:0]        neuron_idx_t; // weight row select

    ////////////////////////////////////////
    // vectors
    ////////////////////////////////////////

    typedef act_t    [`NN_INPUTS-1:0]  act_vec_t;    // element 0 is the first input
    typedef weight_t [`NN_INPUTS-1:0]  weight_row_t; // weights of one neuron
    typedef act_t    [`NN_NEURONS-1:0] result_vec_t; // one sum per neuron
    typedef logic    [`NN_NEURONS-1:0] flag_vec_t;   // one bit per neuron

endpackage

// ==== source/nn_ctrl_pkg.sv ====
package nn_ctrl_pkg;

    // per-neuron multiply-accumulate control
    typedef enum logic [1:0] {
        NRN_IDLE, // waiting for all three operands
        NRN_CALC, // one product per cycle
        NRN_DONE  // sum on display until taken
    } neuron_state_t;

    // layer level control
    typedef enum logic [1:0] {
        SEQ_ACCEPT,   // in_ready high
        SEQ_DISPATCH, // operand valids to every neuron
        SEQ_COLLECT,  // wait for every sum_valid
        SEQ_PRESENT   // out_valid high
    } seq_state_t;

endpackage

// ==== source/operand_slot.sv ====
module operand_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t data_in,
    input  logic     valid,
    output logic     ready,
    output payload_t data_out,
    output logic     held,
    input  logic     clear     // frees the slot for the next payload
);

    payload_t data_q;
    logic     held_q;
    logic     take;

    assign take = valid && !held_q;   // transfer only into an empty slot

    always_ff @(posedge clk) begin
        if (rst) begin
            held_q <= 1'b0;
        end else if (clear) begin
            held_q <= 1'b0;
        end else if (take) begin
            held_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            data_q <= data_in;
        end
    end

    assign ready    = ~held_q;
    assign held     = held_q;
    assign data_out = data_q;

endmodule

// ==== source/neuron.sv ====
`include "nn_cfg.svh"

module neuron (
    input  logic                     clk,
    input  logic                     rst,
    input  nn_data_pkg::count_t      count,
    input  logic                     count_valid,
    output logic                     count_ready,
    input  nn_data_pkg::act_vec_t    inputs,
    input  logic                     inputs_valid,
    output logic                     inputs_ready,
    input  nn_data_pkg::weight_row_t weights,
    input  logic                     weights_valid,
    output logic                     weights_ready,
    output nn_data_pkg::act_t        sum,
    output logic                     overflow,
    output logic                     sum_valid,
    input  logic                     sum_ready
);

    import nn_data_pkg::*;
    import nn_ctrl_pkg::*;

    localparam int ACC_W  = `NN_DATA_W + `NN_FRAC;
    localparam int PROD_W = `NN_DATA_W + `NN_WEIGHT_W;
    localparam int WIDE_W = PROD_W + 1;   // product plus accumulator never exceeds this

    ////////////////////////////////////////
    // operand slots
    ////////////////////////////////////////

    count_t      cnt_q;
    act_vec_t    vec_q;
    weight_row_t wgt_q;
    logic        cnt_held;
    logic        vec_held;
    logic        wgt_held;
    logic        taken;

    assign taken = sum_valid && sum_ready;   // result leaves, slots empty out

    operand_slot #(.payload_t(count_t)) u_count_slot (
        .clk      (clk),
        .rst      (rst),
        .data_in  (count),
        .valid    (count_valid),
        .ready    (count_ready),
        .data_out (cnt_q),
        .held     (cnt_held),
        .clear    (taken)
    );

    operand_slot #(.payload_t(act_vec_t)) u_inputs_slot (
        .clk      (clk),
        .rst      (rst),
        .data_in  (inputs),
        .valid    (inputs_valid),
        .ready    (inputs_ready),
        .data_out (vec_q),
        .held     (vec_held),
        .clear    (taken)
    );

    operand_slot #(.payload_t(weight_row_t)) u_weights_slot (
        .clk      (clk),
        .rst      (rst),
        .data_in  (weights),
        .valid    (weights_valid),
        .ready    (weights_ready),
        .data_out (wgt_q),
        .held     (wgt_held),
        .clear    (taken)
    );

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////

    neuron_state_t             state;
    count_t                    idx_q;    // current input position
    acc_t                      acc_q;
    logic                      ovf_q;    // sticky
    act_t                      cur_act;
    weight_t                   cur_wgt;
    logic signed [PROD_W-1:0]  product;
    logic signed [WIDE_W-1:0]  wide_sum;
    logic [WIDE_W-ACC_W:0]     wide_top;
    logic                      add_ovf;
    logic                      last_step;

    assign cur_act  = vec_q[idx_q];
    assign cur_wgt  = wgt_q[idx_q];
    assign product  = cur_act * cur_wgt;   // full precision
    assign wide_sum = acc_q + product;
    assign wide_top = wide_sum[WIDE_W-1:ACC_W-1];
    assign add_ovf  = !((&wide_top) || !(|wide_top));   // top bits must all match the sign
    assign last_step = (idx_q + 1'b1) >= cnt_q;          // also ends a zero count after one cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= NRN_IDLE;
            ovf_q <= 1'b0;
        end else begin
            case (state)
                NRN_IDLE: begin
                    ovf_q <= 1'b0;
                    if (cnt_held && vec_held && wgt_held) begin
                        state <= NRN_CALC;
                    end
                end
                NRN_CALC: begin
                    if (idx_q < cnt_q) begin
                        ovf_q <= ovf_q | add_ovf;
                    end
                    if (last_step) begin
                        state <= NRN_DONE;
                    end
                end
                NRN_DONE: begin
                    if (sum_ready) begin
                        state <= NRN_IDLE;
                    end
                end
                default: state <= NRN_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == NRN_IDLE) begin
            idx_q <= '0;
            acc_q <= '0;
        end else if (state == NRN_CALC) begin
            idx_q <= idx_q + 1'b1;
            if (idx_q < cnt_q) begin
                acc_q <= wide_sum[ACC_W-1:0];   // wraps
            end
        end
    end

    assign sum       = acc_q[ACC_W-1:`NN_FRAC];
    assign overflow  = ovf_q;
    assign sum_valid = (state == NRN_DONE);

endmodule

// ==== source/weight_bank.sv ====
`include "nn_cfg.svh"

module weight_bank (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      we,
    input  nn_data_pkg::neuron_idx_t                  addr,
    input  nn_data_pkg::weight_row_t                  row_in,
    output nn_data_pkg::weight_row_t [`NN_NEURONS-1:0] rows
);

    import nn_data_pkg::*;

    logic [`NN_NEURONS-1:0] row_sel;   // one-hot write enable

    always_comb begin
        row_sel = '0;
        if (we) begin
            row_sel[addr] = 1'b1;
        end
    end

    ////////////////////////////////////////
    // row storage
    ////////////////////////////////////////

    genvar r;
    generate
        for (r = 0; r < `NN_NEURONS; r++) begin : g_row
            weight_row_t row_q;

            always_ff @(posedge clk) begin
                if (rst) begin
                    row_q <= '0;   // an unloaded layer computes zero
                end else if (row_sel[r]) begin
                    row_q <= row_in;
                end
            end

            assign rows[r] = row_q;   // all rows visible at once
        end
    endgenerate

endmodule

// ==== source/layer_sequencer.sv ====
module layer_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  nn_data_pkg::count_t      in_count,
    input  nn_data_pkg::act_vec_t    in_vec,
    input  logic                     in_valid,
    output logic                     in_ready,
    output nn_data_pkg::count_t      n_count,
    output nn_data_pkg::act_vec_t    n_vec,
    output logic                     n_load,
    input  nn_data_pkg::flag_vec_t   n_done,
    input  nn_data_pkg::result_vec_t n_sums,
    input  nn_data_pkg::flag_vec_t   n_ovf,
    output logic                     n_take,
    output nn_data_pkg::result_vec_t out_sums,
    output nn_data_pkg::flag_vec_t   out_ovf,
    output logic                     out_valid,
    input  logic                     out_ready
);

    import nn_data_pkg::*;
    import nn_ctrl_pkg::*;

    seq_state_t  state;
    count_t      count_q;
    act_vec_t    vec_q;
    result_vec_t sums_q;
    flag_vec_t   ovf_q;
    logic        in_fire;
    logic        all_done;
    logic        out_fire;

    assign in_fire  = in_valid && in_ready;
    assign all_done = &n_done;
    assign out_fire = out_valid && out_ready;

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_ACCEPT;
        end else begin
            case (state)
                SEQ_ACCEPT: begin
                    if (in_fire) begin
                        state <= SEQ_DISPATCH;
                    end
                end
                SEQ_DISPATCH: begin
                    state <= SEQ_COLLECT;   // single cycle of operand valids
                end
                SEQ_COLLECT: begin
                    if (all_done) begin
                        state <= SEQ_PRESENT;
                    end
                end
                SEQ_PRESENT: begin
                    if (out_ready) begin
                        state <= SEQ_ACCEPT;
                    end
                end
                default: state <= SEQ_ACCEPT;
            endcase
        end
    end

    ////////////////////////////////////////
    // payload registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (in_fire) begin
            count_q <= in_count;
            vec_q   <= in_vec;
        end
        if ((state == SEQ_COLLECT) && all_done) begin
            sums_q <= n_sums;   // neurons keep them too until n_take
            ovf_q  <= n_ovf;
        end
    end

    assign in_ready  = (state == SEQ_ACCEPT);
    assign n_load    = (state == SEQ_DISPATCH);
    assign n_count   = count_q;
    assign n_vec     = vec_q;
    assign n_take    = out_fire;   // acknowledge to every neuron
    assign out_valid = (state == SEQ_PRESENT);
    assign out_sums  = sums_q;
    assign out_ovf   = ovf_q;

endmodule

// ==== source/dense_layer.sv ====
`include "nn_cfg.svh"

module dense_layer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     w_we,
    input  nn_data_pkg::neuron_idx_t w_addr,
    input  nn_data_pkg::weight_row_t w_row,
    input  nn_data_pkg::count_t      in_count,
    input  nn_data_pkg::act_vec_t    in_vec,
    input  logic                     in_valid,
    output logic                     in_ready,
    output nn_data_pkg::result_vec_t out_sums,
    output nn_data_pkg::flag_vec_t   out_ovf,
    output logic                     out_valid,
    input  logic                     out_ready
);

    import nn_data_pkg::*;

    weight_row_t [`NN_NEURONS-1:0] rows;
    count_t                        n_count;
    act_vec_t                      n_vec;
    logic                          n_load;
    flag_vec_t                     n_done;
    result_vec_t                   n_sums;
    flag_vec_t                     n_ovf;
    logic                          n_take;

    weight_bank u_weight_bank (
        .clk    (clk),
        .rst    (rst),
        .we     (w_we),
        .addr   (w_addr),
        .row_in (w_row),
        .rows   (rows)
    );

    layer_sequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .in_count  (in_count),
        .in_vec    (in_vec),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .n_count   (n_count),
        .n_vec     (n_vec),
        .n_load    (n_load),
        .n_done    (n_done),
        .n_sums    (n_sums),
        .n_ovf     (n_ovf),
        .n_take    (n_take),
        .out_sums  (out_sums),
        .out_ovf   (out_ovf),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    ////////////////////////////////////////
    // neuron array
    ////////////////////////////////////////

    genvar n;
    generate
        for (n = 0; n < `NN_NEURONS; n++) begin : g_neuron
            neuron u_neuron (
                .clk           (clk),
                .rst           (rst),
                .count         (n_count),
                .count_valid   (n_load),
                .count_ready   (),
                .inputs        (n_vec),
                .inputs_valid  (n_load),
                .inputs_ready  (),
                .weights       (rows[n]),   // straight from the bank
                .weights_valid (n_load),
                .weights_ready (),
                .sum           (n_sums[n]),
                .overflow      (n_ovf[n]),
                .sum_valid     (n_done[n]),
                .sum_ready     (n_take)
            );
        end
    endgenerate

endmodule

// ==== verif/dense_layer_tb.sv ====
`include "nn_cfg.svh"

module dense_layer_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import nn_data_pkg::*;

    localparam int          NUM_VECTORS = 57;
    localparam int          CYCLE_LIMIT = 40 * NUM_VECTORS + 200;
    localparam int          ACC_W       = `NN_DATA_W + `NN_FRAC;
    localparam longint      ACC_MAX     = (longint'(1) << (ACC_W - 1)) - 1;
    localparam longint      ACC_MIN     = -(longint'(1) << (ACC_W - 1));
    localparam logic [31:0] SEED        = 32'h9f6c_c4a4;

    typedef struct packed {
        result_vec_t sums;
        flag_vec_t   ovf;
    } expect_t;

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          w_we;
    neuron_idx_t                   w_addr;
    weight_row_t                   w_row;
    count_t                        in_count;
    act_vec_t                      in_vec;
    logic                          in_valid;
    logic                          in_ready;
    result_vec_t                   out_sums;
    flag_vec_t                     out_ovf;
    logic                          out_valid;
    logic                          out_ready;

    weight_row_t [`NN_NEURONS-1:0] w_model;      // mirror of the weight bank
    expect_t                       expect_q [$];
    expect_t                       head;
    logic [31:0]                   stim_lfsr;
    logic [31:0]                   bp_lfsr;      // back-pressure has its own sequence
    logic [31:0]                   bp_bits;
    logic                          bp_on;
    logic                          hold_pending;
    result_vec_t                   hold_sums;
    flag_vec_t                     hold_ovf;
    int                            sent;
    int                            checked;
    int                            cycles = 0;

    dense_layer uut (
        .clk       (clk),
        .rst       (rst),
        .w_we      (w_we),
        .w_addr    (w_addr),
        .w_row     (w_row),
        .in_count  (in_count),
        .in_vec    (in_vec),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_sums  (out_sums),
        .out_ovf   (out_ovf),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #2 clk = ~clk;   // 4 ns period

    ////////////////////////////////////////
    // random source and reference model
    ////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            st  = lfsr_next(st);
            val = {val[30:0], st[0]};   // one step per bit
        end
    endtask

    function automatic int to_signed(input logic [31:0] r, input int n);
        int v;
        v = int'(r);
        if (r[n-1]) begin
            v = v - (1 << n);
        end
        return v;
    endfunction

    task automatic random_vec(input int n, output act_vec_t v);
        logic [31:0] r;
        for (int i = 0; i < `NN_INPUTS; i++) begin
            draw_bits(stim_lfsr, n, r);
            v[i] = act_t'(to_signed(r, n));
        end
    endtask

    task automatic random_row(input int n, output weight_row_t w);
        logic [31:0] r;
        for (int i = 0; i < `NN_INPUTS; i++) begin
            draw_bits(stim_lfsr, n, r);
            w[i] = weight_t'(to_signed(r, n));
        end
    endtask

    task automatic random_count(output count_t c);
        logic [31:0] r;
        draw_bits(stim_lfsr, 4, r);
        c = count_t'(r % (`NN_INPUTS + 1));
    endtask

    // wrapping accumulation with a sticky range flag per neuron
    function automatic expect_t layer_model(input weight_row_t [`NN_NEURONS-1:0] w,
                                            input act_vec_t v, input count_t c);
        expect_t e;
        acc_t    acc;
        act_t    a;
        weight_t wt;
        longint  wide;
        e = '0;
        for (int n = 0; n < `NN_NEURONS; n++) begin
            acc = '0;
            for (int i = 0; i < int'(c); i++) begin
                a    = v[i];
                wt   = w[n][i];
                wide = longint'(acc) + longint'(a) * longint'(wt);
                if (wide > ACC_MAX || wide < ACC_MIN) begin
                    e.ovf[n] = 1'b1;
                end
                acc = acc_t'(wide);
            end
            e.sums[n] = act_t'(acc >>> `NN_FRAC);
        end
        return e;
    endfunction

    ////////////////////////////////////////
    // checking
    ////////////////////////////////////////

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
            stop_run();
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (hold_pending) begin   // result stalled on the previous edge
                check_equal("out_valid under back-pressure", out_valid, 1);
                check_equal("out_sums under back-pressure", out_sums, hold_sums);
                check_equal("out_ovf under back-pressure", out_ovf, hold_ovf);
            end
            if (out_valid) begin
                check_equal("in_ready while a result waits", in_ready, 0);
            end
            if (out_valid && out_ready) begin
                if (expect_q.size() == 0) begin
                    $display("an output transfer arrived with no vector outstanding");
                    stop_run();
                end else begin
                    head = expect_q.pop_front();
                    for (int n = 0; n < `NN_NEURONS; n++) begin
                        check_equal($sformatf("sum of neuron %0d", n), out_sums[n],
                                    head.sums[n]);
                    end
                    check_equal("overflow flags", out_ovf, head.ovf);
                    checked++;
                end
            end
            hold_pending = out_valid && !out_ready;
            hold_sums    = out_sums;
            hold_ovf     = out_ovf;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_run();
        end
    end

    always @(negedge clk) begin
        if (bp_on) begin
            draw_bits(bp_lfsr, 2, bp_bits);
            out_ready = (bp_bits[1:0] == 2'b00);   // mostly low in stretches
        end else begin
            out_ready = 1'b1;
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    // every driver task starts and ends just after a falling edge
    task automatic wait_results();
        while (checked != sent) @(negedge clk);
    endtask

    task automatic write_row(input int idx, input weight_row_t row);
        wait_results();   // no vector in flight during a write
        w_we         = 1'b1;
        w_addr       = neuron_idx_t'(idx);
        w_row        = row;
        w_model[idx] = row;
        @(negedge clk);
        w_we = 1'b0;
    endtask

    task automatic send_vector(input count_t c, input act_vec_t v);
        in_count = c;
        in_vec   = v;
        in_valid = 1'b1;
        while (!in_ready) @(negedge clk);
        @(negedge clk);   // transfer on the rising edge in between
        expect_q.push_back(layer_model(w_model, v, c));
        sent++;
        in_valid = 1'b0;
    endtask

    initial begin
        act_vec_t    v;
        weight_row_t w;
        count_t      c;
        rst          = 1'b1;
        w_we         = 1'b0;
        w_addr       = '0;
        w_row        = '0;
        in_count     = '0;
        in_vec       = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b1;
        bp_on        = 1'b0;
        hold_pending = 1'b0;
        stim_lfsr    = SEED;
        bp_lfsr      = SEED;
        w_model      = '0;
        sent         = 0;
        checked      = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        check_equal("in_ready after reset", in_ready, 1);
        check_equal("out_valid after reset", out_valid, 0);

        repeat (2) begin   // weights still zero
            random_vec(10, v);
            send_vector(count_t'(`NN_INPUTS), v);
        end

        for (int k = 0; k < `NN_NEURONS; k++) begin
            random_row(5, w);
            write_row(k, w);
        end
        repeat (12) begin
            random_vec(6, v);
            send_vector(count_t'(`NN_INPUTS), v);
        end
        random_vec(6, v);
        send_vector('0, v);
        repeat (15) begin
            random_count(c);
            random_vec(6, v);
            send_vector(c, v);
        end

        // constant rows 1 2 3 and -2 against full-scale inputs leave range only in neuron 2
        for (int k = 0; k < `NN_NEURONS; k++) begin
            for (int i = 0; i < `NN_INPUTS; i++) begin
                w[i] = weight_t'((k == 3) ? -2 : k + 1);
            end
            write_row(k, w);
        end
        for (int i = 0; i < `NN_INPUTS; i++) begin
            v[i] = act_t'((1 << (`NN_DATA_W - 1)) - 1);
        end
        send_vector(count_t'(`NN_INPUTS), v);
        for (int k = 0; k < `NN_NEURONS; k++) begin
            random_row(4 + 3 * k, w);   // wider weights for higher neurons
            write_row(k, w);
        end
        repeat (10) begin
            random_vec(10, v);
            send_vector(count_t'(`NN_INPUTS), v);
        end

        bp_on = 1'b1;
        repeat (8) begin
            random_count(c);
            random_vec(10, v);
            send_vector(c, v);
        end
        wait_results();
        bp_on = 1'b0;

        for (int k = 0; k < `NN_NEURONS; k++) begin
            random_row(5, w);
            write_row(k, w);
        end
        random_vec(6, v);
        for (int k = 0; k < `NN_NEURONS; k++) begin   // same vector around each rewrite
            send_vector(count_t'(`NN_INPUTS), v);
            random_row(5, w);
            write_row(k, w);
            send_vector(count_t'(`NN_INPUTS), v);
        end

        wait_results();
        if (checked == NUM_VECTORS && expect_q.size() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("only %0d of %0d results were checked", checked, NUM_VECTORS);
            stop_run();
        end
    end

endmodule

// ==== build.f ====
+incdir+source
source/nn_data_pkg.sv
source/nn_ctrl_pkg.sv
source/operand_slot.sv
source/neuron.sv
source/weight_bank.sv
source/layer_sequencer.sv
source/dense_layer.sv
verif/dense_layer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module dense_layer_tb -f build.f \
    -o sim_dense_layer > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_dense_layer > sim.log 2>&1
grep -q "Result: FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Result: PASSED" sim.log && echo "simulation passed" \
    || { echo "no result found in sim.log"; exit 1; }
